// File: include/backend_defines.svh
// Global widths, RAM depth and control level codes
// for the memory-access back end

`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BE_XLEN     64      // Register and data width
`define BE_PC_W     64
`define BE_INST_W   32

// RAM index in double words, so 8 bits give 2 KiB
`define BE_RAM_AW   8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control levels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BE_RST_ENA  1'b0    // Active reset level
`define BE_STOP     1'b1    // Stage stopped
`define BE_NOSTOP   1'b0    // Stage running

`endif

// File: logic/backend_pkg.sv
// Shared types of the back end: vector typedefs,
// instruction type and load/store select codes, load FSM states

`include "backend_defines.svh"

package backend_pkg;

    typedef logic [`BE_XLEN-1:0]    reg_t;
    typedef logic [`BE_PC_W-1:0]    pc_t;
    typedef logic [`BE_INST_W-1:0]  inst_t;
    typedef logic [4:0]             reg_addr_t;
    typedef logic [`BE_XLEN-1:0]    daddr_t;    // Byte address into data space

    // Instruction class as seen by MEM
    typedef logic [7:0] inst_type_t;

    localparam inst_type_t IT_NONE  = 8'd0;     // Bubble
    localparam inst_type_t IT_ALU   = 8'd1;
    localparam inst_type_t IT_LOAD  = 8'd2;
    localparam inst_type_t IT_STORE = 8'd3;

    // Size and signedness, same as RISC-V funct3
    typedef logic [2:0] ls_sel_t;

    localparam ls_sel_t LS_B  = 3'd0;
    localparam ls_sel_t LS_H  = 3'd1;
    localparam ls_sel_t LS_W  = 3'd2;
    localparam ls_sel_t LS_D  = 3'd3;
    localparam ls_sel_t LS_BU = 3'd4;
    localparam ls_sel_t LS_HU = 3'd5;
    localparam ls_sel_t LS_WU = 3'd6;

    // Bit 0 IF ... bit 4 WB
    typedef logic [4:0] stall_t;

    typedef enum logic {
        LD_IDLE,
        LD_WAIT     // RAM read in flight
    } load_state_t;

endpackage

// File: logic/ex_mem.sv
// EX/MEM pipeline register with hold and bubble under the stall vector

`include "backend_defines.svh"

module ex_mem (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  backend_pkg::stall_t     stall_ctrl_i,
    input  backend_pkg::pc_t        ex_pc_i,
    input  backend_pkg::inst_t      ex_inst_i,
    input  backend_pkg::inst_type_t ex_inst_type_i,
    input  logic                    ex_rd_ena_i,
    input  backend_pkg::reg_t       ex_rd_data_i,
    input  backend_pkg::reg_addr_t  ex_rd_addr_i,
    input  backend_pkg::ls_sel_t    ex_ls_sel_i,
    input  backend_pkg::daddr_t     ex_ls_addr_i,
    output backend_pkg::pc_t        mem_pc_o,
    output backend_pkg::inst_t      mem_inst_o,
    output backend_pkg::inst_type_t mem_inst_type_o,
    output logic                    mem_rd_ena_o,
    output backend_pkg::reg_t       mem_rd_data_o,
    output backend_pkg::reg_addr_t  mem_rd_addr_o,
    output backend_pkg::ls_sel_t    mem_ls_sel_o,
    output backend_pkg::daddr_t     mem_ls_addr_o
);
    import backend_pkg::*;

    logic ex_stop;
    logic mem_stop;

    assign ex_stop  = (stall_ctrl_i[2] == `BE_STOP);
    assign mem_stop = (stall_ctrl_i[3] == `BE_STOP);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (arst_n_i == `BE_RST_ENA) begin
            mem_pc_o        <= '0;
            mem_inst_o      <= '0;
            mem_inst_type_o <= IT_NONE;
            mem_rd_ena_o    <= 1'b0;
            mem_rd_data_o   <= '0;
            mem_rd_addr_o   <= '0;
            mem_ls_sel_o    <= '0;
            mem_ls_addr_o   <= '0;
        end else if (ex_stop && mem_stop) begin
            // Hold, e.g. a load waiting for the RAM
        end else if (ex_stop) begin
            mem_pc_o        <= '0;      // Bubble into MEM
            mem_inst_o      <= '0;
            mem_inst_type_o <= IT_NONE;
            mem_rd_ena_o    <= 1'b0;
            mem_rd_data_o   <= '0;
            mem_rd_addr_o   <= '0;
            mem_ls_sel_o    <= '0;
            mem_ls_addr_o   <= '0;
        end else begin
            mem_pc_o        <= ex_pc_i;
            mem_inst_o      <= ex_inst_i;
            mem_inst_type_o <= ex_inst_type_i;
            mem_rd_ena_o    <= ex_rd_ena_i;
            mem_rd_data_o   <= ex_rd_data_i;
            mem_rd_addr_o   <= ex_rd_addr_i;
            mem_ls_sel_o    <= ex_ls_sel_i;
            mem_ls_addr_o   <= ex_ls_addr_i;
        end
    end

endmodule

// File: logic/mem_access.sv
// Load/store stage: lane alignment, byte masks, load extension
// and the one-cycle load-wait FSM

`include "backend_defines.svh"

module mem_access (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  backend_pkg::pc_t        mem_pc_i,
    input  backend_pkg::inst_t      mem_inst_i,
    input  backend_pkg::inst_type_t mem_inst_type_i,
    input  logic                    mem_rd_ena_i,
    input  backend_pkg::reg_t       mem_rd_data_i,
    input  backend_pkg::reg_addr_t  mem_rd_addr_i,
    input  backend_pkg::ls_sel_t    mem_ls_sel_i,
    input  backend_pkg::daddr_t     mem_ls_addr_i,
    input  backend_pkg::reg_t       ram_rdata_i,
    output logic [`BE_RAM_AW-1:0]   ram_addr_o,
    output logic [7:0]              ram_wmask_o,
    output backend_pkg::reg_t       ram_wdata_o,
    output logic                    ram_ren_o,
    output logic                    load_stall_req_o,
    output backend_pkg::pc_t        wb_pc_o,
    output backend_pkg::inst_t      wb_inst_o,
    output logic                    wb_rd_ena_o,
    output backend_pkg::reg_t       wb_rd_data_o,
    output backend_pkg::reg_addr_t  wb_rd_addr_o
);
    import backend_pkg::*;

    load_state_t state;
    logic        is_load;
    logic        is_store;
    logic [2:0]  byte_off;
    logic [7:0]  size_mask;
    reg_t        load_shift;
    reg_t        load_val;

    assign is_load  = (mem_inst_type_i == IT_LOAD);
    assign is_store = (mem_inst_type_i == IT_STORE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address, lane and mask
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (mem_ls_sel_i[1:0])
            2'b00:   begin size_mask = 8'h01; byte_off = mem_ls_addr_i[2:0];           end
            2'b01:   begin size_mask = 8'h03; byte_off = {mem_ls_addr_i[2:1], 1'b0};  end
            2'b10:   begin size_mask = 8'h0f; byte_off = {mem_ls_addr_i[2], 2'b00};   end
            default: begin size_mask = 8'hff; byte_off = 3'd0;                         end
        endcase
    end

    assign ram_addr_o  = mem_ls_addr_i[`BE_RAM_AW+2:3];   // Double-word index
    assign ram_wmask_o = is_store ? (size_mask << byte_off) : 8'h00;
    assign ram_wdata_o = mem_rd_data_i << {byte_off, 3'b000};
    assign ram_ren_o   = is_load && (state == LD_IDLE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load wait FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (arst_n_i == `BE_RST_ENA) begin
            state <= LD_IDLE;
        end else begin
            case (state)
                LD_IDLE: if (is_load) state <= LD_WAIT;
                default: state <= LD_IDLE;      // Read word is valid now
            endcase
        end
    end

    assign load_stall_req_o = is_load && (state == LD_IDLE);

    // Addressed bytes moved down to bit 0, then extended
    assign load_shift = ram_rdata_i >> {byte_off, 3'b000};

    always_comb begin
        case (mem_ls_sel_i)
            LS_B:    load_val = {{(`BE_XLEN-8){load_shift[7]}}, load_shift[7:0]};
            LS_H:    load_val = {{(`BE_XLEN-16){load_shift[15]}}, load_shift[15:0]};
            LS_W:    load_val = {{(`BE_XLEN-32){load_shift[31]}}, load_shift[31:0]};
            LS_BU:   load_val = {{(`BE_XLEN-8){1'b0}}, load_shift[7:0]};
            LS_HU:   load_val = {{(`BE_XLEN-16){1'b0}}, load_shift[15:0]};
            LS_WU:   load_val = {{(`BE_XLEN-32){1'b0}}, load_shift[31:0]};
            default: load_val = load_shift;     // LS_D
        endcase
    end

    // Record towards MEM/WB
    assign wb_pc_o      = mem_pc_i;
    assign wb_inst_o    = mem_inst_i;
    assign wb_rd_ena_o  = mem_rd_ena_i;
    assign wb_rd_addr_o = mem_rd_addr_i;
    assign wb_rd_data_o = (is_load && state == LD_WAIT) ? load_val : mem_rd_data_i;

endmodule

// File: logic/data_ram.sv
// Single-port data RAM, 64-bit words, byte write enables
// and registered read

`include "backend_defines.svh"

module data_ram (
    input  logic                    clk,
    input  logic [7:0]              wen_mask_i,
    input  logic [`BE_RAM_AW-1:0]   addr_i,
    input  backend_pkg::reg_t       wdata_i,
    input  logic                    ren_i,
    output backend_pkg::reg_t       rdata_o
);
    import backend_pkg::*;

    localparam int DEPTH = 1 << `BE_RAM_AW;

    reg_t mem [DEPTH];

    // Contents start at zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 8; b++) begin
            if (wen_mask_i[b]) begin
                mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    // Read word valid one cycle after ren_i, held otherwise
    always_ff @(posedge clk) begin
        if (ren_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

// File: logic/mem_wb.sv
// MEM/WB pipeline register, drives the write-back port

`include "backend_defines.svh"

module mem_wb (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  backend_pkg::stall_t     stall_ctrl_i,
    input  backend_pkg::pc_t        mem_pc_i,
    input  backend_pkg::inst_t      mem_inst_i,
    input  logic                    mem_rd_ena_i,
    input  backend_pkg::reg_t       mem_rd_data_i,
    input  backend_pkg::reg_addr_t  mem_rd_addr_i,
    output backend_pkg::pc_t        wb_pc_o,
    output backend_pkg::inst_t      wb_inst_o,
    output logic                    wb_rd_ena_o,
    output backend_pkg::reg_t       wb_rd_data_o,
    output backend_pkg::reg_addr_t  wb_rd_addr_o
);

    logic mem_stop;
    logic wb_stop;

    assign mem_stop = (stall_ctrl_i[3] == `BE_STOP);
    assign wb_stop  = (stall_ctrl_i[4] == `BE_STOP);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (arst_n_i == `BE_RST_ENA) begin
            wb_pc_o      <= '0;
            wb_inst_o    <= '0;
            wb_rd_ena_o  <= 1'b0;
            wb_rd_data_o <= '0;
            wb_rd_addr_o <= '0;
        end else if (wb_stop) begin
            // Hold the write-back record
        end else if (mem_stop) begin
            // MEM still busy, so nothing retires this cycle
            wb_pc_o      <= '0;
            wb_inst_o    <= '0;
            wb_rd_ena_o  <= 1'b0;
            wb_rd_data_o <= '0;
            wb_rd_addr_o <= '0;
        end else begin
            wb_pc_o      <= mem_pc_i;
            wb_inst_o    <= mem_inst_i;
            wb_rd_ena_o  <= mem_rd_ena_i;
            wb_rd_data_o <= mem_rd_data_i;
            wb_rd_addr_o <= mem_rd_addr_i;
        end
    end

endmodule

// File: logic/pipe_ctrl.sv
// Pipeline control, stall requests to the five-bit stall vector

`include "backend_defines.svh"

module pipe_ctrl (
    input  logic                ex_stall_req_i,
    input  logic                load_stall_req_i,
    output backend_pkg::stall_t stall_ctrl_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Priority: load wait over execute stall
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch and decode requests would slot in below these
    always_comb begin
        stall_ctrl_o = {5{`BE_NOSTOP}};
        if (load_stall_req_i) begin
            // Freeze IF..MEM, bubble into WB
            stall_ctrl_o[3:0] = {4{`BE_STOP}};
        end else if (ex_stall_req_i) begin
            stall_ctrl_o[2:0] = {3{`BE_STOP}};  // Bubble into MEM
        end
    end

endmodule

// File: logic/backend_top.sv
// Back end top: EX/MEM, load/store stage, data RAM,
// MEM/WB and pipeline control

`include "backend_defines.svh"

module backend_top (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  backend_pkg::pc_t        ex_pc_i,
    input  backend_pkg::inst_t      ex_inst_i,
    input  backend_pkg::inst_type_t ex_inst_type_i,
    input  logic                    ex_rd_ena_i,
    input  backend_pkg::reg_t       ex_rd_data_i,    // Store data for stores
    input  backend_pkg::reg_addr_t  ex_rd_addr_i,
    input  backend_pkg::ls_sel_t    ex_ls_sel_i,
    input  backend_pkg::daddr_t     ex_ls_addr_i,
    input  logic                    ex_stall_req_i,
    output logic                    ex_stall_o,
    output backend_pkg::pc_t        wb_pc_o,
    output backend_pkg::inst_t      wb_inst_o,
    output logic                    wb_rd_ena_o,
    output backend_pkg::reg_t       wb_rd_data_o,
    output backend_pkg::reg_addr_t  wb_rd_addr_o
);
    import backend_pkg::*;

    stall_t      stall_ctrl;
    logic        load_stall_req;

    pc_t         mem_pc;
    inst_t       mem_inst;
    inst_type_t  mem_inst_type;
    logic        mem_rd_ena;
    reg_t        mem_rd_data;
    reg_addr_t   mem_rd_addr;
    ls_sel_t     mem_ls_sel;
    daddr_t      mem_ls_addr;

    pc_t         ma_pc;         // mem_access to MEM/WB
    inst_t       ma_inst;
    logic        ma_rd_ena;
    reg_t        ma_rd_data;
    reg_addr_t   ma_rd_addr;

    logic [`BE_RAM_AW-1:0] ram_addr;
    logic [7:0]  ram_wmask;
    reg_t        ram_wdata;
    logic        ram_ren;
    reg_t        ram_rdata;

    assign ex_stall_o = stall_ctrl[2];

    ex_mem u_ex_mem (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .stall_ctrl_i    (stall_ctrl),
        .ex_pc_i         (ex_pc_i),
        .ex_inst_i       (ex_inst_i),
        .ex_inst_type_i  (ex_inst_type_i),
        .ex_rd_ena_i     (ex_rd_ena_i),
        .ex_rd_data_i    (ex_rd_data_i),
        .ex_rd_addr_i    (ex_rd_addr_i),
        .ex_ls_sel_i     (ex_ls_sel_i),
        .ex_ls_addr_i    (ex_ls_addr_i),
        .mem_pc_o        (mem_pc),
        .mem_inst_o      (mem_inst),
        .mem_inst_type_o (mem_inst_type),
        .mem_rd_ena_o    (mem_rd_ena),
        .mem_rd_data_o   (mem_rd_data),
        .mem_rd_addr_o   (mem_rd_addr),
        .mem_ls_sel_o    (mem_ls_sel),
        .mem_ls_addr_o   (mem_ls_addr)
    );

    mem_access u_mem_access (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .mem_pc_i         (mem_pc),
        .mem_inst_i       (mem_inst),
        .mem_inst_type_i  (mem_inst_type),
        .mem_rd_ena_i     (mem_rd_ena),
        .mem_rd_data_i    (mem_rd_data),
        .mem_rd_addr_i    (mem_rd_addr),
        .mem_ls_sel_i     (mem_ls_sel),
        .mem_ls_addr_i    (mem_ls_addr),
        .ram_rdata_i      (ram_rdata),
        .ram_addr_o       (ram_addr),
        .ram_wmask_o      (ram_wmask),
        .ram_wdata_o      (ram_wdata),
        .ram_ren_o        (ram_ren),
        .load_stall_req_o (load_stall_req),
        .wb_pc_o          (ma_pc),
        .wb_inst_o        (ma_inst),
        .wb_rd_ena_o      (ma_rd_ena),
        .wb_rd_data_o     (ma_rd_data),
        .wb_rd_addr_o     (ma_rd_addr)
    );

    data_ram u_data_ram (
        .clk        (clk),
        .wen_mask_i (ram_wmask),
        .addr_i     (ram_addr),
        .wdata_i    (ram_wdata),
        .ren_i      (ram_ren),
        .rdata_o    (ram_rdata)
    );

    mem_wb u_mem_wb (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_ctrl_i  (stall_ctrl),
        .mem_pc_i      (ma_pc),
        .mem_inst_i    (ma_inst),
        .mem_rd_ena_i  (ma_rd_ena),
        .mem_rd_data_i (ma_rd_data),
        .mem_rd_addr_i (ma_rd_addr),
        .wb_pc_o       (wb_pc_o),
        .wb_inst_o     (wb_inst_o),
        .wb_rd_ena_o   (wb_rd_ena_o),
        .wb_rd_data_o  (wb_rd_data_o),
        .wb_rd_addr_o  (wb_rd_addr_o)
    );

    pipe_ctrl u_pipe_ctrl (
        .ex_stall_req_i   (ex_stall_req_i),
        .load_stall_req_i (load_stall_req),
        .stall_ctrl_o     (stall_ctrl)
    );

endmodule

// File: tb/backend_tb.sv
// Testbench for the back end: random EX stream, byte-image reference model,
// write-back scoreboard, compare tasks and watchdog

`include "backend_defines.svh"

module backend_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import backend_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int N_ALU           = 20;
    localparam int N_LDST          = 64;
    localparam int N_ESTALL        = 30;
    localparam int N_MIX           = 300;
    localparam int N_TOTAL         = N_ALU + N_LDST + N_ESTALL + N_MIX;
    localparam int WATCHDOG_CYCLES = 20 * N_TOTAL + 100;
    localparam int WIN_BASE        = 'h100;    // Small data window
    localparam int WIN_BYTES       = 64;

    typedef struct {
        pc_t       pc;
        inst_t     inst;
        reg_addr_t rd_addr;
        reg_t      rd_data;
        int        acc_cyc;     // Edge at which EX/MEM took it
        int        latency;
    } wb_exp_t;

    logic       clk = 1'b0;
    logic       arst_n_i;
    pc_t        ex_pc_i;
    inst_t      ex_inst_i;
    inst_type_t ex_inst_type_i;
    logic       ex_rd_ena_i;
    reg_t       ex_rd_data_i;
    reg_addr_t  ex_rd_addr_i;
    ls_sel_t    ex_ls_sel_i;
    daddr_t     ex_ls_addr_i;
    logic       ex_stall_req_i;
    logic       ex_stall_o;
    pc_t        wb_pc_o;
    inst_t      wb_inst_o;
    logic       wb_rd_ena_o;
    reg_t       wb_rd_data_o;
    reg_addr_t  wb_rd_addr_o;

    // Reference model state
    logic [7:0] img [0:2047];
    wb_exp_t    exp_q [$];

    integer     seed = 8;
    string      test_name;
    int         cyc = 0;
    int         last_load = -10;
    int         err_phase;
    int         err_total = 0;
    int         n_tests = 0;
    int         n_pass = 0;
    int         issued;
    int         phase_count;
    int         stall_left;
    bit         en_alu, en_load, en_store, en_estall;
    logic       pending = 1'b0;     // Offered record not yet taken
    pc_t        next_pc = 64'h1000;

    inst_type_t p_type;
    ls_sel_t    p_sel;
    int         p_addr;
    reg_t       p_data;
    pc_t        p_pc;
    inst_t      p_inst;
    reg_addr_t  p_rd;

    backend_top UUT (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .ex_pc_i        (ex_pc_i),
        .ex_inst_i      (ex_inst_i),
        .ex_inst_type_i (ex_inst_type_i),
        .ex_rd_ena_i    (ex_rd_ena_i),
        .ex_rd_data_i   (ex_rd_data_i),
        .ex_rd_addr_i   (ex_rd_addr_i),
        .ex_ls_sel_i    (ex_ls_sel_i),
        .ex_ls_addr_i   (ex_ls_addr_i),
        .ex_stall_req_i (ex_stall_req_i),
        .ex_stall_o     (ex_stall_o),
        .wb_pc_o        (wb_pc_o),
        .wb_inst_o      (wb_inst_o),
        .wb_rd_ena_o    (wb_rd_ena_o),
        .wb_rd_data_o   (wb_rd_data_o),
        .wb_rd_addr_o   (wb_rd_addr_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Model helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int rnd(input int n);
        rnd = int'($unsigned($random(seed)) % n);
    endfunction

    // Little-endian gather, then extension by funct3 code
    function automatic reg_t model_load(input ls_sel_t sel, input int addr);
        reg_t raw;
        int   size;
        raw  = '0;
        size = 1 << sel[1:0];
        for (int i = 0; i < size; i++) begin
            raw[i*8 +: 8] = img[addr+i];
        end
        case (sel)
            LS_B:    model_load = {{56{raw[7]}}, raw[7:0]};
            LS_H:    model_load = {{48{raw[15]}}, raw[15:0]};
            LS_W:    model_load = {{32{raw[31]}}, raw[31:0]};
            default: model_load = raw;      // Unsigned and double
        endcase
    endfunction

    task automatic model_store(input ls_sel_t sel, input int addr, input reg_t data);
        int size;
        size = 1 << sel[1:0];
        for (int i = 0; i < size; i++) begin
            img[addr+i] = data[i*8 +: 8];
        end
    endtask

    task automatic note_error();
        err_phase++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_reg(input string what, input reg_t exp, input reg_t act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            note_error();
        end
    endtask

    task automatic check_addr(input string what, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            note_error();
        end
    endtask

    task automatic check_pc(input string what, input pc_t exp, input pc_t act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            note_error();
        end
    endtask

    task automatic check_inst(input string what, input inst_t exp, input inst_t act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            note_error();
        end
    endtask

    task automatic check_stall(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %s %s at cycle %0d: expected %b, actual %b",
                     test_name, what, cyc, exp, act);
            note_error();
        end
    endtask

    task automatic check_latency(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            note_error();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic make_instr();
        int k;
        int size;
        k = rnd(3);
        while (!((k == 0 && en_alu) || (k == 1 && en_load) || (k == 2 && en_store))) begin
            k = rnd(3);
        end
        p_pc    = next_pc;
        next_pc = next_pc + 64'd4;
        p_inst  = inst_t'($random(seed));
        p_rd    = reg_addr_t'(1 + rnd(31));
        p_data  = {$random(seed), $random(seed)};
        p_type  = (k == 0) ? IT_ALU : (k == 1) ? IT_LOAD : IT_STORE;
        p_sel   = (k == 1) ? ls_sel_t'(rnd(7)) : ls_sel_t'(rnd(4));
        size    = 1 << p_sel[1:0];
        p_addr  = WIN_BASE + (rnd(WIN_BYTES) & ~(size - 1));   // Size-aligned
    endtask

    task automatic drive_pending();
        ex_pc_i        <= p_pc;
        ex_inst_i      <= p_inst;
        ex_inst_type_i <= p_type;
        ex_rd_ena_i    <= (p_type != IT_STORE);
        ex_rd_data_i   <= p_data;
        ex_rd_addr_i   <= p_rd;
        ex_ls_sel_i    <= p_sel;
        ex_ls_addr_i   <= daddr_t'(p_addr);
        ex_stall_req_i <= 1'b0;
    endtask

    // Junk record offered under an execute stall, must never retire
    task automatic drive_garbage();
        ex_pc_i        <= {$random(seed), $random(seed)};
        ex_inst_i      <= inst_t'($random(seed));
        ex_inst_type_i <= inst_type_t'(rnd(4));
        ex_rd_ena_i    <= 1'b1;
        ex_rd_data_i   <= {$random(seed), $random(seed)};
        ex_rd_addr_i   <= reg_addr_t'(rnd(32));
        ex_ls_sel_i    <= ls_sel_t'(rnd(7));
        ex_ls_addr_i   <= daddr_t'(WIN_BASE + rnd(WIN_BYTES));
        ex_stall_req_i <= 1'b1;
    endtask

    task automatic drive_idle();
        ex_pc_i        <= '0;
        ex_inst_i      <= '0;
        ex_inst_type_i <= IT_NONE;
        ex_rd_ena_i    <= 1'b0;
        ex_rd_data_i   <= '0;
        ex_rd_addr_i   <= '0;
        ex_ls_sel_i    <= '0;
        ex_ls_addr_i   <= '0;
        ex_stall_req_i <= 1'b0;
    endtask

    task automatic accept_pending();
        wb_exp_t e;
        e.pc      = p_pc;
        e.inst    = p_inst;
        e.rd_addr = p_rd;
        e.acc_cyc = cyc;
        e.rd_data = p_data;
        e.latency = 2;
        if (p_type == IT_STORE) begin
            model_store(p_sel, p_addr, p_data);
        end else begin
            if (p_type == IT_LOAD) begin
                e.rd_data = model_load(p_sel, p_addr);
                e.latency = 3;                  // One wait cycle in MEM
                last_load = cyc;
            end
            exp_q.push_back(e);
        end
    endtask

    // One clock: score write-back, check stall, then offer the next record
    task automatic step();
        wb_exp_t e;
        logic    acc;
        @(posedge clk);
        cyc++;
        if (wb_rd_ena_o) begin
            if (exp_q.size() == 0) begin
                $display("%s: write-back at cycle %0d with nothing outstanding", test_name, cyc);
                note_error();
            end else begin
                e = exp_q.pop_front();
                check_pc("wb pc", e.pc, wb_pc_o);
                check_inst("wb inst", e.inst, wb_inst_o);
                check_addr("wb rd addr", e.rd_addr, wb_rd_addr_o);
                check_reg("wb rd data", e.rd_data, wb_rd_data_o);
                check_latency("latency", e.latency, cyc - e.acc_cyc);
            end
        end
        check_stall("ex_stall_o", (last_load == cyc - 1) || ex_stall_req_i, ex_stall_o);
        acc = pending && !ex_stall_o;
        if (acc) begin
            accept_pending();
        end
        if (pending && !acc) begin
            return;     // Producer holds its record
        end
        pending = 1'b0;
        if (stall_left > 0) begin
            stall_left--;
            drive_garbage();
        end else if (issued < phase_count && en_estall && rnd(6) == 0) begin
            stall_left = rnd(3);                // Burst of 1 to 3 cycles
            drive_garbage();
        end else if (issued < phase_count) begin
            make_instr();
            drive_pending();
            pending = 1'b1;
            issued++;
        end else begin
            drive_idle();
        end
    endtask

    task automatic run_test(input string name, input int count, input bit alu,
                            input bit load, input bit store, input bit estall);
        test_name   = name;
        phase_count = count;
        en_alu      = alu;
        en_load     = load;
        en_store    = store;
        en_estall   = estall;
        issued      = 0;
        stall_left  = 0;
        err_phase   = 0;
        while (issued < phase_count || pending || stall_left > 0) begin
            step();
        end
        while (exp_q.size() > 0) begin
            step();
        end
        repeat (6) step();      // Catch stray write-backs
        n_tests++;
        if (err_phase == 0) begin
            n_pass++;
            $display("%-16s PASS", name);
        end else begin
            $display("%-16s FAIL (%0d errors)", name, err_phase);
        end
        err_total += err_phase;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, write-backs still missing", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        for (int i = 0; i < 2048; i++) begin
            img[i] = 8'h00;
        end
        arst_n_i       = 1'b0;
        ex_pc_i        = '0;
        ex_inst_i      = '0;
        ex_inst_type_i = IT_NONE;
        ex_rd_ena_i    = 1'b0;
        ex_rd_data_i   = '0;
        ex_rd_addr_i   = '0;
        ex_ls_sel_i    = '0;
        ex_ls_addr_i   = '0;
        ex_stall_req_i = 1'b0;
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;

        run_test("reset_idle", 0, 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("alu_latency", N_ALU, 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("load_store", N_LDST, 1'b0, 1'b1, 1'b1, 1'b0);
        run_test("exec_stall", N_ESTALL, 1'b1, 1'b0, 1'b0, 1'b1);
        run_test("random_mix", N_MIX, 1'b1, 1'b1, 1'b1, 1'b1);

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 n_tests, n_pass, n_tests - n_pass, err_total);
        if (err_total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
logic/backend_pkg.sv
logic/ex_mem.sv
logic/mem_access.sv
logic/data_ram.sv
logic/mem_wb.sv
logic/pipe_ctrl.sv
logic/backend_top.sv
tb/backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := backend_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/backend_defines.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
